// ==== tb/rapcore_patterns.txt ====
0 FE00000000000000 0 0 0 100
1 0A00000000000001 0 0 0 1
3 100000000000C805 0 0 0 C805
2 200000000000000A 0 0 0 A
4 0100000000000001 100 80000000 0 80
4 0100000000000000 64 40000000 0 19
4 0100000000000001 20 100000000 0 20
5 A 3 0 0 7
4 0100000000000000 100 0 1000000 7F
4 0100000000000001 80 80000000 FFFFFFFFFF000000 20
1 0A00000000000000 0 0 0 0
2 2000000000000028 0 0 0 28
6 0100000000000001 200 40000000 0 200
7 0 0 0 0 1

// ==== filelist.f ====
+incdir+hw
hw/rapcore_pkg.sv
hw/move_if.sv
hw/spi_word.sv
hw/command_decoder.sv
hw/move_buffer.sv
hw/dda_timer.sv
hw/quad_enc.sv
hw/rapcore.sv
tb/rapcore_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the rapcore testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
  --top-module rapcore_tb -Mdir obj_dir -o rapcore_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/rapcore_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^SIMULATION PASSED$" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// ==== tb/rapcore_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rapcore_consts.svh"

module rapcore_tb;

  logic       CLK;
  logic       resetn;
  logic       SCK;
  logic       CS;
  logic       COPI;
  logic       ENC_A;
  logic       ENC_B;
  logic       HALT;
  wire        CIPO;
  wire        STEP;
  wire        DIR;
  wire        ENABLE;
  wire  [2:0] MICROSTEPS;
  wire  [7:0] CURRENT;
  wire        BUFFER_DTR;
  wire        MOVE_DONE;
  wire        ENC_FAULT;

  // Pattern table with one entry per file line
  logic [63:0] p_kind [64];
  logic [63:0] p_w0 [64];
  logic [63:0] p_w1 [64];
  logic [63:0] p_w2 [64];
  logic [63:0] p_w3 [64];
  logic [63:0] p_exp [64];
  int          n_pat;
  int          step_cnt = 0;
  int          done_cnt = 0;
  longint      cycles = 0;
  longint      limit = 20000;
  longint      enc_net = 0;
  longint      cur_div = 40;

  rapcore dut (.CLK(CLK), .resetn(resetn), .SCK(SCK), .CS(CS), .COPI(COPI), .ENC_A(ENC_A),
    .ENC_B(ENC_B), .HALT(HALT), .CIPO(CIPO), .STEP(STEP), .DIR(DIR), .ENABLE(ENABLE),
    .MICROSTEPS(MICROSTEPS), .CURRENT(CURRENT), .BUFFER_DTR(BUFFER_DTR),
    .MOVE_DONE(MOVE_DONE), .ENC_FAULT(ENC_FAULT));

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  // STEP and MOVE_DONE pulse counters
  always @(posedge CLK) begin
    if (resetn) begin
      if (STEP) step_cnt <= step_cnt + 1;
      if (MOVE_DONE) done_cnt <= done_cnt + 1;
    end
  end

  // Run length guard
  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
      $display("Timeout: run went past %0d clock cycles", limit);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  end

  // Inputs change 2 ns after the rising edge
  task automatic wait_cycles(input longint n);
    repeat (n) begin
      @(posedge CLK);
      #2;
    end
  endtask

  task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  endtask

  // Mode 0 word at SCK = CLK/10 with CS released after each word
  task automatic spi_xfer(input logic [63:0] tx, output logic [63:0] rx);
    int gap;
    CS = 1'b0;
    for (int i = 63; i >= 0; i--) begin
      COPI = tx[i];
      wait_cycles(5);
      rx[i] = CIPO;
      SCK = 1'b1;
      wait_cycles(5);
      SCK = 1'b0;
    end
    wait_cycles(5);
    CS   = 1'b1;
    COPI = 1'b0;
    // Random idle gap between words
    gap = 8 + int'($urandom % 8);
    wait_cycles(gap);
  endtask

  // Sends header, duration, increment and accel words and returns the increment reply
  task automatic send_move(input logic [63:0] hdr, input logic [63:0] dur,
                           input logic [63:0] inc, input logic [63:0] acc,
                           output logic [63:0] snap);
    logic [63:0] r;
    spi_xfer(hdr, r);
    spi_xfer(dur, r);
    spi_xfer(inc, snap);
    spi_xfer(acc, r);
  endtask

  // Gray steps with A leading B when up is set
  task automatic enc_drive(input longint n, input bit up);
    for (longint i = 0; i < n; i++) begin
      if ((ENC_A == ENC_B) == up) ENC_A = ~ENC_A;
      else ENC_B = ~ENC_B;
      wait_cycles(4);
    end
  endtask

  // Step count from the tick rule in 32.32 fixed point
  function automatic longint dda_steps(input logic [63:0] dur, input logic [63:0] inc0,
                                       input logic [63:0] acc_step);
    logic [63:0] acc;
    logic [63:0] inc;
    logic [63:0] nxt;
    longint      n;
    acc = '0;
    inc = inc0;
    n   = 0;
    for (logic [63:0] t = 0; t < dur; t++) begin
      nxt = acc + inc;
      if (nxt[63:32] != acc[63:32]) n++;
      acc = nxt;
      inc = inc + acc_step;
    end
    return n;
  endfunction

  task automatic run_move(input int i);
    int          base_s;
    int          base_d;
    logic [63:0] snap;
    base_s = step_cnt;
    base_d = done_cnt;
    check("recomputed step count", 64'(dda_steps(p_w1[i], p_w2[i], p_w3[i])), p_exp[i]);
    send_move(p_w0[i], p_w1[i], p_w2[i], p_w3[i], snap);
    check("encoder snapshot", snap, 64'(enc_net));
    wait_cycles(6);
    check("DIR during move", {63'd0, DIR}, {63'd0, p_w0[i][0]});
    while (done_cnt == base_d) wait_cycles(1);
    wait_cycles(2);
    check("move step count", 64'(step_cnt - base_s), p_exp[i]);
  endtask

  task automatic run_burst(input int i);
    int          nb;
    int          base_s;
    int          base_d;
    int          held;
    logic [63:0] snap;
    nb     = (1 << `MOVE_BUFFER_BITS) + 1;
    base_s = step_cnt;
    base_d = done_cnt;
    check("burst total", 64'((nb - 1) * dda_steps(p_w1[i], p_w2[i], p_w3[i])), p_exp[i]);
    for (int m = 0; m < nb; m++) begin
      send_move(p_w0[i], p_w1[i], p_w2[i], p_w3[i], snap);
      check("burst encoder snapshot", snap, 64'(enc_net));
      wait_cycles(4);
      // Ready drops once all four slots are taken
      check("BUFFER_DTR", {63'd0, BUFFER_DTR}, (m < nb - 2) ? 64'd1 : 64'd0);
    end
    HALT = 1'b1;
    wait_cycles(2);
    held = step_cnt;
    wait_cycles(1000);
    check("steps while halted", 64'(step_cnt), 64'(held));
    HALT = 1'b0;
    while (done_cnt - base_d < nb - 1) wait_cycles(1);
    // Long enough for a fifth move to show up if it had been kept
    wait_cycles(p_w1[i] * cur_div + 200);
    check("MOVE_DONE pulses", 64'(done_cnt - base_d), 64'(nb - 1));
    check("burst step count", 64'(step_cnt - base_s), p_exp[i]);
    check("BUFFER_DTR after drain", {63'd0, BUFFER_DTR}, 64'd1);
  endtask

  initial begin
    int          fd;
    int          code;
    logic [63:0] r;
    void'($urandom(32'h302574a7));
    resetn = 1'b0;
    SCK    = 1'b0;
    CS     = 1'b1;
    COPI   = 1'b0;
    ENC_A  = 1'b0;
    ENC_B  = 1'b0;
    HALT   = 1'b0;
    wait_cycles(5);
    resetn = 1'b1;
    wait_cycles(2);

    fd = $fopen("tb/rapcore_patterns.txt", "r");
    if (fd == 0) begin
      $display("Pattern file tb/rapcore_patterns.txt could not be opened");
      $display("SIMULATION FAILED");
      $fatal(1);
    end
    n_pat = 0;
    code  = 6;
    while (code == 6 && n_pat < 64) begin
      code = $fscanf(fd, " %h %h %h %h %h %h", p_kind[n_pat], p_w0[n_pat], p_w1[n_pat],
                     p_w2[n_pat], p_w3[n_pat], p_exp[n_pat]);
      if (code == 6) n_pat++;
    end
    $fclose(fd);

    // Cycle budget from move time plus SPI words plus slack
    for (int i = 0; i < n_pat; i++) begin
      case (p_kind[i])
        64'd2: cur_div = longint'(p_w0[i][7:0]);
        64'd4: limit += longint'(p_w1[i]) * cur_div + 4000;
        64'd6: limit += ((1 << `MOVE_BUFFER_BITS) + 1) * (longint'(p_w1[i]) * cur_div + 4000);
        default: limit += 2000;
      endcase
    end
    cur_div = 40;

    // Reset defaults
    check("STEP after reset", {63'd0, STEP}, 64'd0);
    check("MOVE_DONE after reset", {63'd0, MOVE_DONE}, 64'd0);
    check("ENABLE after reset", {63'd0, ENABLE}, 64'd0);
    check("BUFFER_DTR after reset", {63'd0, BUFFER_DTR}, 64'd1);
    check("CIPO after reset", {63'd0, CIPO}, 64'd0);
    check("MICROSTEPS after reset", {61'd0, MICROSTEPS}, 64'd2);
    check("CURRENT after reset", {56'd0, CURRENT}, 64'd140);

    for (int i = 0; i < n_pat; i++) begin
      case (p_kind[i])
        64'd0: begin
          spi_xfer(p_w0[i], r);
          spi_xfer(64'd0, r);
          check("API version", {40'd0, r[23:0]}, p_exp[i]);
        end
        64'd1: begin
          spi_xfer(p_w0[i], r);
          wait_cycles(4);
          check("ENABLE", {63'd0, ENABLE}, p_exp[i]);
        end
        64'd2: begin
          spi_xfer(p_w0[i], r);
          wait_cycles(4);
          cur_div = longint'(p_w0[i][7:0]);
          check("clock divisor", {56'd0, dut.clock_divisor}, p_exp[i]);
        end
        64'd3: begin
          spi_xfer(p_w0[i], r);
          wait_cycles(4);
          check("CURRENT and MICROSTEPS", {48'd0, CURRENT, 5'd0, MICROSTEPS}, p_exp[i]);
        end
        64'd4: run_move(i);
        64'd5: begin
          enc_drive(longint'(p_w0[i]), 1'b1);
          enc_drive(longint'(p_w1[i]), 1'b0);
          enc_net = enc_net + longint'(p_w0[i]) - longint'(p_w1[i]);
          check("encoder count", 64'(dut.encoder_count), p_exp[i]);
          // Legal Gray steps leave the fault flag clear
          check("ENC_FAULT after Gray steps", {63'd0, ENC_FAULT}, 64'd0);
        end
        64'd6: run_burst(i);
        64'd7: begin
          // Both phases at once is not a Gray step
          ENC_A = ~ENC_A;
          ENC_B = ~ENC_B;
          wait_cycles(5);
          check("ENC_FAULT", {63'd0, ENC_FAULT}, p_exp[i]);
        end
        default: begin
          $display("Pattern line %0d has unknown kind %h", i, p_kind[i]);
          $display("SIMULATION FAILED");
          $fatal(1);
        end
      endcase
    end

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== hw/rapcore.sv ====
`timescale 1ns/1ps
`default_nettype none

module rapcore import rapcore_pkg::*; (
  input  logic       CLK,
  input  logic       resetn,
  input  logic       SCK,
  input  logic       CS,
  input  logic       COPI,
  input  logic       ENC_A,
  input  logic       ENC_B,
  input  logic       HALT,
  output logic       CIPO,
  output logic       STEP,
  output logic       DIR,
  output logic       ENABLE,
  output logic [2:0] MICROSTEPS,
  output logic [7:0] CURRENT,
  output logic       BUFFER_DTR,
  output logic       MOVE_DONE,
  output logic       ENC_FAULT
);

  spi_word_t          rx_word;
  spi_word_t          tx_word;
  logic               word_received;
  logic        [7:0]  clock_divisor;
  logic signed [63:0] encoder_count;

  // Decoder to buffer, buffer head to DDA
  move_if move_wr ();
  move_if move_rd ();

  spi_word u_spi (.CLK(CLK), .resetn(resetn), .SCK(SCK), .CS(CS), .COPI(COPI),
    .CIPO(CIPO), .tx_word(tx_word), .rx_word(rx_word), .word_received(word_received));

  command_decoder u_dec (.CLK(CLK), .resetn(resetn), .word_received(word_received),
    .rx_word(rx_word), .tx_word(tx_word), .encoder_count(encoder_count),
    .enable(ENABLE), .clock_divisor(clock_divisor), .microsteps(MICROSTEPS),
    .current(CURRENT), .move(move_wr));

  move_buffer u_buf (.CLK(CLK), .resetn(resetn), .wr(move_wr), .rd(move_rd),
    .move_done(MOVE_DONE), .buffer_dtr(BUFFER_DTR));

  dda_timer u_dda (.CLK(CLK), .resetn(resetn), .clock_divisor(clock_divisor),
    .halt(HALT), .move(move_rd), .step(STEP), .dir(DIR), .move_done(MOVE_DONE));

  quad_enc u_enc (.CLK(CLK), .resetn(resetn), .a(ENC_A), .b(ENC_B),
    .count(encoder_count), .fault(ENC_FAULT));

endmodule

`default_nettype wire

// ==== hw/quad_enc.sv ====
`timescale 1ns/1ps
`default_nettype none

module quad_enc (
  input  logic               CLK,
  input  logic               resetn,
  input  logic               a,
  input  logic               b,
  output logic signed [63:0] count,
  output logic               fault
);

  // Bits 1:0 synchronize, bit 2 is previous state
  logic [2:0] a_q;
  logic [2:0] b_q;
  logic       a_chg;
  logic       b_chg;
  logic       up;

  assign a_chg = a_q[1] ^ a_q[2];
  assign b_chg = b_q[1] ^ b_q[2];
  // A leading B counts up
  assign up    = a_q[1] ^ b_q[2];

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      a_q   <= '0;
      b_q   <= '0;
      count <= '0;
      fault <= 1'b0;
    end else begin
      a_q <= {a_q[1:0], a};
      b_q <= {b_q[1:0], b};
      // Both phases moving is an illegal Gray step, sticky
      if (a_chg && b_chg) begin
        fault <= 1'b1;
      end else if (a_chg || b_chg) begin
        count <= up ? count + 64'sd1 : count - 64'sd1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/dda_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module dda_timer (
  input  logic       CLK,
  input  logic       resetn,
  input  logic [7:0] clock_divisor,
  input  logic       halt,
  move_if.sink       move,
  output logic       step,
  output logic       dir,
  output logic       move_done
);

  logic        [7:0]  div_cnt;
  logic        [63:0] tick_cnt;
  logic signed [63:0] acc;
  logic signed [63:0] inc_run;
  logic signed [63:0] acc_next;
  logic               active;
  logic               tick;

  // Divider wraps after clock_divisor cycles
  assign tick     = ({1'b0, div_cnt} + 9'd1) >= {1'b0, clock_divisor};
  assign acc_next = acc + inc_run;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      active    <= 1'b0;
      div_cnt   <= '0;
      tick_cnt  <= '0;
      acc       <= '0;
      inc_run   <= '0;
      step      <= 1'b0;
      dir       <= 1'b0;
      move_done <= 1'b0;
    end else begin
      step      <= 1'b0;
      move_done <= 1'b0;
      if (move.valid) dir <= move.dir;
      if (!active) begin
        // Old head still visible while move_done pops it
        if (move.valid && !move_done) begin
          active   <= 1'b1;
          div_cnt  <= '0;
          tick_cnt <= '0;
          acc      <= '0;
          inc_run  <= move.increment;
        end
      end else if (!halt) begin
        if (tick) begin
          div_cnt  <= '0;
          acc      <= acc_next;
          inc_run  <= inc_run + move.accel;
          tick_cnt <= tick_cnt + 64'd1;
          // Step on a carry or borrow into the integer half
          step     <= acc_next[63:32] != acc[63:32];
          if (tick_cnt + 64'd1 >= move.duration) begin
            move_done <= 1'b1;
            active    <= 1'b0;
            acc       <= '0;
          end
        end else begin
          div_cnt <= div_cnt + 8'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/move_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rapcore_consts.svh"

module move_buffer (
  input  logic   CLK,
  input  logic   resetn,
  move_if.sink   wr,
  move_if.source rd,
  input  logic   move_done,
  output logic   buffer_dtr
);

  localparam logic [`MOVE_BUFFER_BITS:0] DEPTH = 1 << `MOVE_BUFFER_BITS;

  logic        [63:0]                 dur_mem [DEPTH];
  logic signed [63:0]                 inc_mem [DEPTH];
  logic signed [63:0]                 acc_mem [DEPTH];
  logic                               dir_mem [DEPTH];
  logic        [`MOVE_BUFFER_BITS-1:0] wr_ptr;
  logic        [`MOVE_BUFFER_BITS-1:0] rd_ptr;
  logic        [`MOVE_BUFFER_BITS:0]   fill;
  logic                               push;
  logic                               pop;

  // Full buffer drops the write
  assign push       = wr.valid && (fill != DEPTH);
  assign pop        = move_done && (fill != '0);
  assign buffer_dtr = fill < DEPTH;

  // Head entry straight from storage
  assign rd.valid     = fill != '0;
  assign rd.duration  = dur_mem[rd_ptr];
  assign rd.increment = inc_mem[rd_ptr];
  assign rd.accel     = acc_mem[rd_ptr];
  assign rd.dir       = dir_mem[rd_ptr];

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      // Simultaneous push and pop keeps fill
      if (push && !pop) fill <= fill + 1'b1;
      else if (pop && !push) fill <= fill - 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (push) begin
      dur_mem[wr_ptr] <= wr.duration;
      inc_mem[wr_ptr] <= wr.increment;
      acc_mem[wr_ptr] <= wr.accel;
      dir_mem[wr_ptr] <= wr.dir;
    end
  end

  // DDA only finishes moves it got from here
  a_no_done_when_empty: assert property (@(posedge CLK) disable iff (!resetn)
    move_done |-> fill != '0);

endmodule

`default_nettype wire

// ==== hw/command_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rapcore_consts.svh"

module command_decoder import rapcore_pkg::*; (
  input  logic               CLK,
  input  logic               resetn,
  input  logic               word_received,
  input  spi_word_t          rx_word,
  output spi_word_t          tx_word,
  input  logic signed [63:0] encoder_count,
  output logic               enable,
  output logic        [7:0]  clock_divisor,
  output logic        [2:0]  microsteps,
  output logic        [7:0]  current,
  move_if.source             move
);

  // Saved header of a multi word message
  cmd_t               header;
  // 0 means next word is a header
  logic        [2:0]  word_idx;
  logic signed [63:0] encoder_snap;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      header        <= '0;
      word_idx      <= '0;
      tx_word.raw   <= '0;
      enable        <= 1'b0;
      clock_divisor <= 8'd40;
      microsteps    <= 3'd2;
      current       <= 8'd140;
      move.valid    <= 1'b0;
    end else begin
      move.valid <= 1'b0;
      if (word_received) begin
        // Reply defaults to zero
        tx_word.raw <= '0;
        if (word_idx == 3'd0) begin
          header <= rx_word.hdr.cmd;
          case (rx_word.hdr.cmd)
            `CMD_COORDINATED_STEP: word_idx <= 3'd1;
            `CMD_MOTOR_ENABLE: enable <= rx_word.hdr.fields[0];
            `CMD_CLK_DIVISOR: clock_divisor <= rx_word.hdr.fields[7:0];
            `CMD_MOTORCONFIG: begin
              current    <= rx_word.hdr.fields[15:8];
              microsteps <= rx_word.hdr.fields[2:0];
            end
            // Answer goes out during the next word
            `CMD_API_VERSION: tx_word.raw <= {40'd0, `VERSION_MAJOR, `VERSION_MINOR,
                                              `VERSION_PATCH};
            default: ;
          endcase
        end else if (header == `CMD_COORDINATED_STEP) begin
          case (word_idx)
            // Duration word, snapshot returns with increment word
            3'd1: tx_word.raw <= encoder_snap;
            // Accel word closes the message
            3'd3: move.valid <= 1'b1;
            default: ;
          endcase
          word_idx <= (word_idx == 3'd3) ? 3'd0 : word_idx + 3'd1;
        end else begin
          word_idx <= 3'd0;
        end
      end
    end
  end

  // Move fields and encoder snapshot
  always_ff @(posedge CLK) begin
    if (word_received) begin
      case (word_idx)
        3'd0: begin
          if (rx_word.hdr.cmd == `CMD_COORDINATED_STEP) begin
            move.dir     <= rx_word.raw[0];
            encoder_snap <= encoder_count;
          end
        end
        3'd1: move.duration <= rx_word.raw;
        3'd2: move.increment <= rx_word.raw;
        3'd3: move.accel <= rx_word.raw;
        default: ;
      endcase
    end
  end

  a_word_idx_range: assert property (@(posedge CLK) disable iff (!resetn)
    word_idx <= 3'd3);

endmodule

`default_nettype wire

// ==== hw/spi_word.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_word import rapcore_pkg::*; (
  input  logic      CLK,
  input  logic      resetn,
  input  logic      SCK,
  input  logic      CS,
  input  logic      COPI,
  output logic      CIPO,
  input  spi_word_t tx_word,
  output spi_word_t rx_word,
  output logic      word_received
);

  // Two sync flops plus a third SCK flop for edge detect
  logic [2:0]  sck_q;
  logic [1:0]  cs_q;
  logic [1:0]  copi_q;
  logic [5:0]  bit_cnt;
  logic [63:0] rx_shift;
  logic [63:0] tx_shift;
  logic        sck_rise;
  logic        sck_fall;

  assign sck_rise = sck_q[1] & ~sck_q[2];
  assign sck_fall = ~sck_q[1] & sck_q[2];
  // MSB first
  assign CIPO = tx_shift[63];

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      sck_q  <= '0;
      cs_q   <= 2'b11;
      copi_q <= '0;
    end else begin
      sck_q  <= {sck_q[1:0], SCK};
      cs_q   <= {cs_q[0], CS};
      copi_q <= {copi_q[0], COPI};
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      bit_cnt       <= '0;
      tx_shift      <= '0;
      word_received <= 1'b0;
    end else begin
      word_received <= 1'b0;
      if (cs_q[1]) begin
        // Preload reply for the first bit while deselected
        bit_cnt  <= '0;
        tx_shift <= tx_word.raw;
      end else if (sck_rise) begin
        // Counter wraps to 0 after 64th bit
        bit_cnt <= bit_cnt + 6'd1;
        if (bit_cnt == 6'd63) begin
          word_received <= 1'b1;
        end
      end else if (sck_fall) begin
        // Reload at a word boundary with CS held low
        if (bit_cnt == 6'd0) begin
          tx_shift <= tx_word.raw;
        end else begin
          tx_shift <= {tx_shift[62:0], 1'b0};
        end
      end
    end
  end

  // Receive shifter and word capture
  always_ff @(posedge CLK) begin
    if (!cs_q[1] && sck_rise) begin
      rx_shift <= {rx_shift[62:0], copi_q[1]};
      if (bit_cnt == 6'd63) begin
        rx_word.raw <= {rx_shift[62:0], copi_q[1]};
      end
    end
  end

  // Word must complete before host deselects
  a_no_word_while_cs_high: assert property (@(posedge CLK) disable iff (!resetn)
    word_received |-> !cs_q[1]);

endmodule

`default_nettype wire

// ==== hw/move_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// One move, valid qualifies the other fields
interface move_if;
  logic               valid;
  logic        [63:0] duration;
  logic signed [63:0] increment;
  logic signed [63:0] accel;
  logic               dir;

  modport source (output valid, output duration, output increment, output accel,
                  output dir);
  modport sink (input valid, input duration, input increment, input accel,
                input dir);
endinterface

`default_nettype wire

// ==== hw/rapcore_pkg.sv ====
`default_nettype none

package rapcore_pkg;

  // One header byte
  typedef logic [7:0] cmd_t;

  // Header view of a word, command in the top byte
  typedef struct packed {
    cmd_t        cmd;
    logic [55:0] fields;
  } spi_hdr_t;

  // Same 64 bits read as payload or as header
  typedef union packed {
    logic [63:0] raw;
    spi_hdr_t    hdr;
  } spi_word_t;

endpackage

`default_nettype wire

// ==== hw/rapcore_consts.svh ====
`ifndef RAPCORE_CONSTS_SVH
`define RAPCORE_CONSTS_SVH

// Header byte codes, top byte of the first word of a message
`define CMD_COORDINATED_STEP 8'h01
`define CMD_MOTOR_ENABLE     8'h0A
`define CMD_MOTORCONFIG      8'h10
`define CMD_CLK_DIVISOR      8'h20
`define CMD_API_VERSION      8'hFE

// Move buffer depth as log2, 4 entries
`define MOVE_BUFFER_BITS 2

// API version 0.1.0
`define VERSION_MAJOR 8'd0
`define VERSION_MINOR 8'd1
`define VERSION_PATCH 8'd0

`endif
